// ==== include/mapper_config.svh ====
/*
  Fixed dimensions of the 68000 memory mapper.
  Include wherever a region count, register depth, mailbox index
  or acknowledge function code is needed.
*/
`ifndef MAPPER_CONFIG_SVH
`define MAPPER_CONFIG_SVH

// number of decoded address regions
`define MAPPER_REGIONS 8

// depth of the byte register file
`define MAPPER_MMR_WORDS 32

// register index shared with the sound CPU as a mailbox
`define MAPPER_SND_LATCH 3

// 68000 function code of an interrupt acknowledge cycle
`define MAPPER_IACK_FC 7

// first register of the region descriptor block
// control byte at base+2n, base byte at base+2n+1
`define MAPPER_REGION_REG 16

`endif

// ==== src/mapper_pkg.sv ====
/*
  Types shared by the mapper blocks and its testbench.
  Refer to them by scoped name, e.g. mapper_pkg::region_sel_t.
*/
package mapper_pkg;

`include "mapper_config.svh"

    // register file index and payload
    typedef logic [4:0] mmr_addr_t;
    typedef logic [7:0] mmr_data_t;

    // region span, picks how many of addr[23:16] take part in the compare
    typedef enum logic [1:0] {
        SIZE_64K  = 2'd0,   // 8 bits compared
        SIZE_128K = 2'd1,   // 7 bits
        SIZE_512K = 2'd2,   // 5 bits
        SIZE_2M   = 2'd3    // 3 bits
    } region_size_e;

    // wait code: 0..2 give 1..3 cycles, 3 asks for external acknowledge
    typedef logic [1:0] dtack_cyc_t;

    // one unpacked region descriptor
    typedef struct packed {
        mmr_data_t    base;
        dtack_cyc_t   dtack;
        region_size_e size;
    } region_cfg_t;

    typedef region_cfg_t [`MAPPER_REGIONS-1:0] region_cfg_array_t;

    // one-hot select, all zero when nothing decodes
    typedef logic [`MAPPER_REGIONS-1:0] region_sel_t;

endpackage

// ==== src/mapper_reg_bus_if.sv ====
/*
  Write port into the mapper register file.
  One instance per requester; the requester drives the write,
  the arbiter answers with busy while that requester is locked out.
*/
`timescale 1ns/1ps

interface mapper_reg_bus_if;

    mapper_pkg::mmr_addr_t addr;
    mapper_pkg::mmr_data_t data;
    // write strobe, one byte per cycle
    logic we;
    // high while the other peer owns the file
    logic busy;

    modport requester (
        output addr, data, we,
        input  busy
    );

    modport arbiter (
        input  addr, data, we,
        output busy
    );

endinterface

// ==== src/mapper_reg_arbiter.sv ====
/*
  Grants the register file to the 68000 or to the MCU.
  The CPU owns it while no region decodes, the MCU while one does.
  Only the granted port's write reaches the file; the other is dropped.
*/
`timescale 1ns/1ps

module mapper_reg_arbiter (
    mapper_reg_bus_if.arbiter           cpu,
    mapper_reg_bus_if.arbiter           mcu,
    input  mapper_pkg::region_sel_t     sel,
    output mapper_pkg::mmr_addr_t       wr_addr,
    output mapper_pkg::mmr_data_t       wr_data,
    output logic                        wr_en
);

    logic cpu_grant;

    // no region active means the CPU is talking to the mapper itself
    assign cpu_grant = (sel == '0);

    // lock-out indication back to each peer
    assign cpu.busy = ~cpu_grant;
    assign mcu.busy = cpu_grant;

    // merged write port
    always_comb begin
        if (cpu_grant) begin
            wr_addr = cpu.addr;
            wr_data = cpu.data;
            wr_en   = cpu.we;
        end else begin
            wr_addr = mcu.addr;
            wr_data = mcu.data;
            wr_en   = mcu.we;
        end
    end

endmodule

// ==== src/mapper_regs.sv ====
/*
  Byte register file of the mapper.
  Unpacks the eight region descriptors for the decoder and keeps
  the sound CPU mailbox flag on the shared latch register.
  Writes land at the next clock edge.
*/
`timescale 1ns/1ps
`include "mapper_config.svh"

module mapper_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  mapper_pkg::mmr_addr_t           wr_addr,
    input  mapper_pkg::mmr_data_t           wr_data,
    input  logic                            wr_en,
    input  logic                            sndmap_rd,
    output mapper_pkg::region_cfg_array_t   cfg,
    output mapper_pkg::mmr_data_t           sndmap_dout,
    output logic                            sndmap_obf
);

    mapper_pkg::mmr_data_t mmr [`MAPPER_MMR_WORDS];

    logic snd_wr;

    assign snd_wr = wr_en && (wr_addr == 5'(`MAPPER_SND_LATCH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAPPER_MMR_WORDS; i++) begin
                mmr[i] <= '0;
            end
            sndmap_obf <= 1'b0;
        end else begin
            if (wr_en) begin
                mmr[wr_addr] <= wr_data;
            end
            // sound CPU read beats a new write in the same cycle
            if (sndmap_rd) begin
                sndmap_obf <= 1'b0;
            end else if (snd_wr) begin
                sndmap_obf <= 1'b1;
            end
        end
    end

    // mailbox byte is always visible to the sound CPU
    assign sndmap_dout = mmr[`MAPPER_SND_LATCH];

    // descriptor unpack, control byte holds {.., dtack[3:2], size[1:0]}
    for (genvar n = 0; n < `MAPPER_REGIONS; n++) begin : g_region
        assign cfg[n].size  = mapper_pkg::region_size_e'(mmr[`MAPPER_REGION_REG + 2*n][1:0]);
        assign cfg[n].dtack = mmr[`MAPPER_REGION_REG + 2*n][3:2];
        assign cfg[n].base  = mmr[`MAPPER_REGION_REG + 2*n + 1];
    end

endmodule

// ==== src/mapper_decode.sv ====
/*
  Address decoder of the mapper.
  Each region compares its base byte against the top address bits that
  its size leaves significant. The lowest matching region wins and its
  wait code is reported. Purely combinational.
*/
`timescale 1ns/1ps
`include "mapper_config.svh"

module mapper_decode (
    input  logic [23:1]                     addr,
    input  logic                            asn,
    input  mapper_pkg::region_cfg_array_t   cfg,
    output mapper_pkg::region_sel_t         sel,
    output mapper_pkg::dtack_cyc_t          dtack_cyc
);

    mapper_pkg::region_sel_t hit;
    mapper_pkg::region_sel_t first;

    // raw per-region match, several may be set when regions overlap
    always_comb begin
        hit = '0;
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            case (cfg[n].size)
                mapper_pkg::SIZE_64K:  hit[n] = addr[23:16] == cfg[n].base;
                mapper_pkg::SIZE_128K: hit[n] = addr[23:17] == cfg[n].base[7:1];
                mapper_pkg::SIZE_512K: hit[n] = addr[23:19] == cfg[n].base[7:3];
                mapper_pkg::SIZE_2M:   hit[n] = addr[23:21] == cfg[n].base[7:5];
                default:               hit[n] = 1'b0;
            endcase
        end
    end

    // isolate the lowest set bit, region 0 has top priority
    assign first = hit & (~hit + 1'b1);

    // nothing is selected outside an address strobe
    assign sel = asn ? '0 : first;

    // wait code of the winning region
    always_comb begin
        dtack_cyc = '0;
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            if (sel[n]) begin
                dtack_cyc = cfg[n].dtack;
            end
        end
    end

endmodule

// ==== src/mapper_irq.sv ====
/*
  Vertical blank interrupt of the mapper.
  A rising vint latches a request on IPL bit 2; the 68000
  interrupt acknowledge cycle autovectors through cpu_vpan
  and clears the request on the next edge.
*/
`timescale 1ns/1ps
`include "mapper_config.svh"

module mapper_irq (
    input  logic        clk,
    input  logic        rst,
    input  logic        vint,
    input  logic [2:0]  cpu_fc,
    input  logic        cpu_asn,
    output logic [2:0]  cpu_ipln,
    output logic        cpu_vpan
);

    logic irq_n;
    logic last_vint;
    logic inta_n;

    // acknowledge cycle: function code 7 under an address strobe
    assign inta_n = ~((cpu_fc == 3'(`MAPPER_IACK_FC)) && !cpu_asn);

    // autovector request follows the acknowledge directly
    assign cpu_vpan = inta_n;

    // only IPL2 is used, giving level 4 on the encoded lines
    assign cpu_ipln = {irq_n, 2'b11};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_n     <= 1'b1;
            last_vint <= 1'b0;
        end else begin
            last_vint <= vint;
            // acknowledge wins over a fresh edge
            if (!inta_n) begin
                irq_n <= 1'b1;
            end else if (vint && !last_vint) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

// ==== src/mapper_top.sv ====
/*
  Memory mapper of a 68000 arcade board.
  Holds the region registers, decodes the CPU address into a one-hot
  region select with its DTACK wait code, shares a mailbox with the
  sound CPU and raises the vertical blank interrupt.
*/
`timescale 1ns/1ps

module mapper_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        vint,
    // 68000 side
    input  logic [23:1]                 addr,
    input  logic [15:0]                 cpu_dout,
    input  logic [1:0]                  cpu_dswn,
    input  logic                        cpu_asn,
    input  logic [2:0]                  cpu_fc,
    output logic [2:0]                  cpu_ipln,
    output logic                        cpu_vpan,
    output mapper_pkg::dtack_cyc_t      dtack_cyc,
    output mapper_pkg::region_sel_t     active,
    // MCU side
    input  mapper_pkg::mmr_addr_t       mcu_addr,
    input  mapper_pkg::mmr_data_t       mcu_dout,
    input  logic                        mcu_wr,
    // sound CPU mailbox
    input  logic                        sndmap_rd,
    output mapper_pkg::mmr_data_t       sndmap_dout,
    output logic                        sndmap_obf
);

    mapper_reg_bus_if cpu_bus ();
    mapper_reg_bus_if mcu_bus ();

    mapper_pkg::mmr_addr_t          wr_addr;
    mapper_pkg::mmr_data_t          wr_data;
    logic                           wr_en;
    mapper_pkg::region_cfg_array_t  cfg;

    // CPU writes the low byte, registers sit on word addresses
    assign cpu_bus.addr = addr[5:1];
    assign cpu_bus.data = cpu_dout[7:0];
    assign cpu_bus.we   = ~cpu_asn & ~cpu_dswn[0];

    assign mcu_bus.addr = mcu_addr;
    assign mcu_bus.data = mcu_dout;
    assign mcu_bus.we   = mcu_wr;

    mapper_reg_arbiter u_arb (
        .cpu     (cpu_bus.arbiter),
        .mcu     (mcu_bus.arbiter),
        .sel     (active),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_en       (wr_en),
        .sndmap_rd   (sndmap_rd),
        .cfg         (cfg),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf)
    );

    mapper_decode u_dec (
        .addr      (addr),
        .asn       (cpu_asn),
        .cfg       (cfg),
        .sel       (active),
        .dtack_cyc (dtack_cyc)
    );

    mapper_irq u_irq (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .cpu_fc   (cpu_fc),
        .cpu_asn  (cpu_asn),
        .cpu_ipln (cpu_ipln),
        .cpu_vpan (cpu_vpan)
    );

endmodule

// ==== bench/mapper_assertions.sv ====
/*
  Concurrent checks bound into mapper_top.
  Covers the one-hot region select, its idle value outside an
  address strobe and the release of IPL2 after an acknowledge.
*/
`timescale 1ns/1ps
`include "mapper_config.svh"

module mapper_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    cpu_asn,
    input logic [2:0]              cpu_fc,
    input logic [2:0]              cpu_ipln,
    input mapper_pkg::region_sel_t active
);

    // at most one region decodes at a time
    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(active))
        else $error("more than one region active");

    // nothing decodes outside an address strobe
    sel_idle: assert property (@(posedge clk) disable iff (rst) cpu_asn |-> active == '0)
        else $error("region active without address strobe");

    // IPL2 released on the edge after an acknowledge cycle
    iack_clear: assert property (@(posedge clk) disable iff (rst)
        (cpu_fc == 3'(`MAPPER_IACK_FC) && !cpu_asn) |=> cpu_ipln[2])
        else $error("interrupt still pending after acknowledge");

endmodule

bind mapper_top mapper_assertions u_assertions (.*);

// ==== bench/mapper_tb.sv ====
/*
  Testbench of the 68000 memory mapper.
  Random CPU, MCU, sound and vblank traffic goes into mapper_top and
  every cycle is compared against a model of the register file, region
  decode, arbitration, sound mailbox and vblank interrupt latch.
*/
`timescale 1ns/1ps
`include "mapper_config.svh"

module mapper_tb;

    localparam int N_DECODE = 200;
    localparam int N_ARB    = 400;
    // reset and first decode, two program passes with their decodes, arbitration and a tail
    localparam int PLANNED  = 4 + 64 + 2 * (16 + N_DECODE) + N_ARB + 16;

    logic clk = 1'b0;
    logic rst, vint, cpu_asn, mcu_wr, sndmap_rd;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0] cpu_dswn;
    logic [2:0] cpu_fc;
    mapper_pkg::mmr_addr_t mcu_addr;
    mapper_pkg::mmr_data_t mcu_dout;
    // DUT outputs
    logic sndmap_obf, cpu_vpan;
    logic [2:0] cpu_ipln;
    mapper_pkg::mmr_data_t sndmap_dout;
    mapper_pkg::dtack_cyc_t dtack_cyc;
    mapper_pkg::region_sel_t active;

    // reference model state
    mapper_pkg::mmr_data_t m_reg [`MAPPER_MMR_WORDS];
    logic m_obf, m_irq_n, m_last_vint;
    integer seed = 32'hdec9_92a4;
    int cycles = 0;

    mapper_top UUT (.*);

    always #2 clk = ~clk;

    // watchdog at four times the planned stimulus length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 4 * PLANNED) begin
            $display("timeout: the run went past %0d cycles", 4 * PLANNED);
            $display("TEST FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sel(input mapper_pkg::region_sel_t got, exp);
        if (got !== exp)
            report_mismatch($sformatf("active %b, expected %b", got, exp));
    endtask
    task automatic check_dtack(input mapper_pkg::dtack_cyc_t got, exp);
        if (got !== exp)
            report_mismatch($sformatf("dtack_cyc %0d, expected %0d", got, exp));
    endtask
    task automatic check_byte(input mapper_pkg::mmr_data_t got, exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s %h, expected %h", what, got, exp));
    endtask
    task automatic check_bit(input logic got, exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s %b, expected %b", what, got, exp));
    endtask

    // lowest region whose significant base bits equal addr[23:16]
    // returns -1 when no region matches
    function automatic int find_region(input logic [23:1] a);
        int shift;
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            case (m_reg[`MAPPER_REGION_REG + 2 * n][1:0])
                2'd0: shift = 0;
                2'd1: shift = 1;
                2'd2: shift = 3;
                default: shift = 5;
            endcase
            if ((a[23:16] >> shift) == (m_reg[`MAPPER_REGION_REG + 2 * n + 1] >> shift))
                return n;
        end
        return -1;
    endfunction

    // compare mid-cycle and then move the model across the edge to the next drive point
    task automatic tick();
        int r;
        logic iack;
        logic we;
        mapper_pkg::mmr_addr_t wa;
        mapper_pkg::mmr_data_t wd;
        mapper_pkg::region_sel_t exp_sel;
        mapper_pkg::dtack_cyc_t exp_dtack;
        #2;
        r = cpu_asn ? -1 : find_region(addr);
        exp_sel = '0;
        exp_dtack = '0;
        if (r >= 0) begin
            exp_sel[r] = 1'b1;
            exp_dtack = m_reg[`MAPPER_REGION_REG + 2 * r][3:2];
        end
        iack = (cpu_fc == 3'(`MAPPER_IACK_FC)) && !cpu_asn;
        check_sel(active, exp_sel);
        check_dtack(dtack_cyc, exp_dtack);
        check_byte(sndmap_dout, m_reg[`MAPPER_SND_LATCH], "sndmap_dout");
        check_bit(sndmap_obf, m_obf, "sndmap_obf");
        check_bit(cpu_vpan, !iack, "cpu_vpan");
        check_bit(cpu_ipln[2], m_irq_n, "cpu_ipln[2]");
        check_bit(&cpu_ipln[1:0], 1'b1, "cpu_ipln[1:0]");
        // CPU owns the file while nothing decodes and the MCU owns it otherwise
        we = (r < 0) ? (!cpu_asn && !cpu_dswn[0]) : mcu_wr;
        wa = (r < 0) ? addr[5:1] : mcu_addr;
        wd = (r < 0) ? cpu_dout[7:0] : mcu_dout;
        if (we)
            m_reg[wa] = wd;
        if (sndmap_rd)
            m_obf = 1'b0;
        else if (we && wa == 5'(`MAPPER_SND_LATCH))
            m_obf = 1'b1;
        if (iack)
            m_irq_n = 1'b1;
        else if (vint && !m_last_vint)
            m_irq_n = 1'b0;
        m_last_vint = vint;
        @(posedge clk);
        #1;
    endtask

    // random cycles with the top address byte masked
    // both peers write when wr is set
    task automatic random_traffic(input int count, input logic [7:0] top_mask, input logic wr);
        repeat (count) begin
            addr = 23'($random(seed));
            addr[23:16] = addr[23:16] & top_mask;
            cpu_asn = ($random(seed) & 3) == 0;
            cpu_dswn = wr ? 2'($random(seed)) : 2'b11;
            // bit 7 of written data stays clear so bases never reach addr[23]
            cpu_dout = 16'($random(seed)) & 16'hff7f;
            mcu_addr = 5'($random(seed));
            mcu_dout = 8'($random(seed)) & 8'h7f;
            mcu_wr = wr & 1'($random(seed));
            sndmap_rd = ($random(seed) & 7) == 0;
            vint = 1'($random(seed));
            cpu_fc = 3'($random(seed));
            tick();
        end
    endtask

    // CPU register write at an addr[23] address that no programmed base decodes
    task automatic cpu_write(input mapper_pkg::mmr_addr_t idx, input mapper_pkg::mmr_data_t d);
        addr = {1'b1, 17'($random(seed)), idx};
        cpu_dout = {8'($random(seed)), d};
        cpu_asn = 1'b0;
        cpu_dswn = 2'b10;
        tick();
        cpu_asn = 1'b1;
        cpu_dswn = 2'b11;
    endtask

    // random size and wait codes with bases limited by mask
    task automatic program_regions(input mapper_pkg::mmr_data_t mask);
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            cpu_write(5'(`MAPPER_REGION_REG + 2 * n), 8'($random(seed)) & 8'h0f);
            cpu_write(5'(`MAPPER_REGION_REG + 2 * n + 1), 8'($random(seed)) & mask & 8'h7f);
        end
    endtask

    initial begin
        rst = 1'b1;
        {vint, mcu_wr, sndmap_rd} = 3'b000;
        cpu_fc = '0;
        mcu_addr = '0;
        mcu_dout = '0;
        addr = '0;
        cpu_dout = '0;
        cpu_dswn = 2'b11;
        cpu_asn = 1'b1;
        m_reg = '{default: '0};
        {m_obf, m_last_vint, m_irq_n} = 3'b001;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // reset leaves every region at base 0 and 64 kB so top byte 0 hits region 0
        random_traffic(32, 8'h00, 1'b0);
        random_traffic(32, 8'hff, 1'b0);
        program_regions(8'h7f);
        random_traffic(N_DECODE, 8'hff, 1'b0);
        // narrow bases make the regions overlap heavily
        program_regions(8'h1f);
        random_traffic(N_DECODE, 8'h3f, 1'b0);
        // both peers write while the decode moves ownership around
        random_traffic(N_ARB, 8'h9f, 1'b1);
        // mailbox cleared, written, read, then a read racing a second write
        mcu_wr = 1'b0;
        sndmap_rd = 1'b1;
        cpu_fc = '0;
        tick();
        sndmap_rd = 1'b0;
        cpu_write(5'(`MAPPER_SND_LATCH), 8'h5a);
        check_bit(sndmap_obf, 1'b1, "sndmap_obf after write");
        sndmap_rd = 1'b1;
        tick();
        cpu_write(5'(`MAPPER_SND_LATCH), 8'ha5);
        sndmap_rd = 1'b0;
        check_bit(sndmap_obf, 1'b0, "sndmap_obf after read with write");
        check_byte(sndmap_dout, 8'ha5, "sndmap_dout");
        // clear any pending request before a vblank edge and its acknowledge
        vint = 1'b0;
        cpu_fc = 3'(`MAPPER_IACK_FC);
        cpu_asn = 1'b0;
        tick();
        cpu_asn = 1'b1;
        vint = 1'b1;
        tick();
        check_bit(cpu_ipln[2], 1'b0, "cpu_ipln[2] after vblank edge");
        cpu_asn = 1'b0;
        tick();
        cpu_asn = 1'b1;
        check_bit(cpu_ipln[2], 1'b1, "cpu_ipln[2] after acknowledge");
        tick();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
src/mapper_pkg.sv
src/mapper_reg_bus_if.sv
src/mapper_reg_arbiter.sv
src/mapper_regs.sv
src/mapper_decode.sv
src/mapper_irq.sv
src/mapper_top.sv
bench/mapper_assertions.sv
bench/mapper_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the mapper testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mapper_tb -f vlog.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vmapper_tb > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"
